// ==== flist.f ====
rtl/cisr_pkg.sv
rtl/credit_fifo.sv
rtl/cisr_row_decoder.sv
rtl/row_accumulator.sv
rtl/result_serializer.sv
rtl/spmv_top.sv
test/tb_spmv.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the SpMV testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_spmv -f flist.f -o sim_tb_spmv

./obj_dir/sim_tb_spmv > sim.log 2>&1 || true
cat sim.log

if grep -F -q "*** TEST PASSED ***" sim.log; then
    exit 0
fi
exit 1

// ==== test/tb_spmv.sv ====
/*
 * SpMV engine testbench
 * random CISR matrices, credit driven host, byte checks against plain row totals
 */
`timescale 1ns/10ps
`default_nettype none

module tb_spmv import cisr_pkg::*; ();

    // ******************************
    // run limits
    // ******************************
    localparam int TOTAL_MATRICES  = 8;
    localparam int WATCHDOG_CYCLES = TOTAL_MATRICES * 2000 + 16 + 200;

    logic        clk;
    logic        rst_l;
    logic        row_len_valid;
    row_len_t    row_len;
    logic        row_len_credit;
    logic        grp_valid;
    elem_group_t grp;
    logic        grp_credit;
    logic        out_valid;
    byte_t       out_byte;
    logic        out_credit;

    int          seed = 84;
    row_len_t    len_q[$];
    elem_group_t grp_q[$];
    byte_t       exp_q[$];
    byte_t       exp_byte;
    // host view of credits and counters
    int          len_cred;
    int          grp_cred;
    int          len_sent;
    int          len_returned;
    int          grp_sent;
    int          grp_returned;
    int          out_view;
    int          owed;
    int          credit_delay = 3;
    logic        idle_check = 1'b0;
    int          errors = 0;
    int          byte_checks = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    spmv_top i_dut (
        .clk, .rst_l,
        .row_len_valid, .row_len, .row_len_credit,
        .grp_valid, .grp, .grp_credit,
        .out_valid, .out_byte, .out_credit
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout, expected bytes did not arrive before the watchdog ran out");
        $display("*** TEST FAILED ***");
        $finish;
    end

    // ******************************
    // host credit bookkeeping
    // ******************************
    always @(posedge clk or negedge rst_l) begin
        if (!rst_l) begin
            len_cred     <= IN_FIFO_DEPTH;
            grp_cred     <= IN_FIFO_DEPTH;
            len_sent     <= 0;
            len_returned <= 0;
            grp_sent     <= 0;
            grp_returned <= 0;
            out_view     <= OUT_CREDITS;
            owed         <= 0;
        end else begin
            len_cred     <= len_cred + int'(row_len_credit) - int'(row_len_valid);
            grp_cred     <= grp_cred + int'(grp_credit) - int'(grp_valid);
            len_sent     <= len_sent + int'(row_len_valid);
            len_returned <= len_returned + int'(row_len_credit);
            grp_sent     <= grp_sent + int'(grp_valid);
            grp_returned <= grp_returned + int'(grp_credit);
            // matches the serializer count one cycle after a pulse
            out_view     <= out_view + int'(out_credit) - int'(out_valid);
            owed         <= owed + int'(out_valid) - int'(out_credit);
        end
    end

    // output credits go back after a random wait
    initial begin
        out_credit = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            out_credit = rst_l && (owed > 0) && (({$random(seed)} % credit_delay) == 0);
        end
    end

    // ******************************
    // assertions
    // ******************************
    a_idle_low: assert property (@(posedge clk)
        idle_check |-> (!out_valid && !row_len_credit && !grp_credit))
        else begin
            errors++;
            $display("output or credit pulse seen before any input");
        end

    a_out_credit: assert property (@(posedge clk) disable iff (!rst_l)
        out_valid |-> (out_view > 0))
        else begin
            errors++;
            $display("out_valid raised with no output credit left");
        end

    a_len_room: assert property (@(posedge clk) disable iff (!rst_l)
        row_len_valid |-> (i_dut.i_len_fifo.level < 3'(IN_FIFO_DEPTH)))
        else begin
            errors++;
            $display("row length pushed into a full FIFO");
        end

    a_grp_room: assert property (@(posedge clk) disable iff (!rst_l)
        grp_valid |-> (i_dut.i_grp_fifo.level < 3'(IN_FIFO_DEPTH)))
        else begin
            errors++;
            $display("element group pushed into a full FIFO");
        end

    a_cred_bound: assert property (@(posedge clk) disable iff (!rst_l)
        (len_cred <= IN_FIFO_DEPTH) && (grp_cred <= IN_FIFO_DEPTH))
        else begin
            errors++;
            $display("more input credit pulses than entries sent");
        end

    // bytes leave in queue order
    always @(posedge clk) begin
        if (rst_l && out_valid) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("byte sent with no result pending");
            end else begin
                exp_byte = exp_q.pop_front();
                byte_checks++;
                assert (out_byte == exp_byte)
                    else begin
                        errors++;
                        $display("mismatch out_byte expected 0x%02h actual 0x%02h",
                                 exp_byte, out_byte);
                    end
            end
        end
    end

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    // CISR layout, lowest free lane takes the next row
    task automatic build_matrix();
        row_len_t    lens     [NUM_ROWS];
        acc_t        sums     [NUM_ROWS];
        int          lane_rem [NUM_LANES];
        int          lane_row [NUM_LANES];
        int          next_row;
        int          busy;
        elem_group_t g;
        next_row = 0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            lens[r] = row_len_t'(1 + ({$random(seed)} % 4));
            sums[r] = '0;
        end
        for (int l = 0; l < NUM_LANES; l++) begin
            lane_rem[l] = 0;
            lane_row[l] = 0;
        end
        busy = 1;
        while (busy != 0) begin
            for (int l = 0; l < NUM_LANES; l++) begin
                if ((lane_rem[l] == 0) && (next_row < NUM_ROWS)) begin
                    lane_row[l] = next_row;
                    lane_rem[l] = int'(lens[next_row]);
                    len_q.push_back(lens[next_row]);
                    next_row++;
                end
                g[l].value = value_t'($random(seed));
                if (lane_rem[l] > 0) begin
                    g[l].col = col_t'({$random(seed)} % 255);
                    sums[lane_row[l]] = sums[lane_row[l]] + acc_t'(g[l].value);
                    lane_rem[l]--;
                end else begin
                    g[l].col = COL_PAD;
                end
            end
            grp_q.push_back(g);
            busy = (next_row < NUM_ROWS) ? 1 : 0;
            for (int l = 0; l < NUM_LANES; l++) begin
                if (lane_rem[l] != 0) begin
                    busy = 1;
                end
            end
        end
        // row 0 first, low byte first
        for (int r = 0; r < NUM_ROWS; r++) begin
            for (int b = 0; b < 4; b++) begin
                exp_q.push_back(byte_t'(sums[r] >> (8 * b)));
            end
        end
    endtask

    // both streams in parallel, groups with random gaps
    task automatic send_streams();
        while ((len_q.size() != 0) || (grp_q.size() != 0)) begin
            row_len_valid = 1'b0;
            grp_valid     = 1'b0;
            if ((len_cred > 0) && (len_q.size() != 0)) begin
                row_len       = len_q.pop_front();
                row_len_valid = 1'b1;
            end
            if ((grp_cred > 0) && (grp_q.size() != 0) && (({$random(seed)} % 4) != 0)) begin
                grp       = grp_q.pop_front();
                grp_valid = 1'b1;
            end
            step();
        end
        row_len_valid = 1'b0;
        grp_valid     = 1'b0;
    endtask

    task automatic drain_and_check();
        while ((exp_q.size() != 0) || (owed != 0)) begin
            step();
        end
        repeat (4) step();
        assert (len_returned == len_sent)
            else begin
                errors++;
                $display("mismatch row_len_credit expected 0x%0h actual 0x%0h",
                         len_sent, len_returned);
            end
        assert (grp_returned == grp_sent)
            else begin
                errors++;
                $display("mismatch grp_credit expected 0x%0h actual 0x%0h",
                         grp_sent, grp_returned);
            end
    endtask

    task automatic end_test(input string name, input int err_before);
        tests_run++;
        if (errors != err_before) begin
            tests_failed++;
        end
        $display("test %0d %s: %s", tests_run, name,
                 (errors == err_before) ? "ok" : "failed");
    endtask

    // ******************************
    // test sequence
    // ******************************
    initial begin
        int err_mark;
        rst_l         = 1'b0;
        row_len_valid = 1'b0;
        row_len       = '0;
        grp_valid     = 1'b0;
        grp           = '0;
        repeat (16) @(posedge clk);
        #1;
        rst_l = 1'b1;

        err_mark   = errors;
        idle_check = 1'b1;
        repeat (20) step();
        idle_check = 1'b0;
        end_test("idle after reset", err_mark);

        err_mark = errors;
        build_matrix();
        send_streams();
        drain_and_check();
        end_test("single matrix", err_mark);

        err_mark = errors;
        for (int m = 0; m < 3; m++) begin
            build_matrix();
            send_streams();
            drain_and_check();
        end
        end_test("random lane layouts", err_mark);

        // slow host, serializer has to stall
        err_mark     = errors;
        credit_delay = 12;
        build_matrix();
        send_streams();
        drain_and_check();
        credit_delay = 3;
        end_test("late output credits", err_mark);

        err_mark = errors;
        build_matrix();
        send_streams();
        drain_and_check();
        end_test("input credit count", err_mark);

        err_mark = errors;
        build_matrix();
        build_matrix();
        send_streams();
        drain_and_check();
        end_test("back to back matrices", err_mark);

        repeat (20) step();
        $display("tests %0d, failed %0d, bytes checked %0d, errors %0d",
                 tests_run, tests_failed, byte_checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rtl/spmv_top.sv ====
/*
 * SpMV engine top
 * CISR input queues, row decoder, row sums and byte output
 */
`timescale 1ns/10ps
`default_nettype none

module spmv_top import cisr_pkg::*; (
    input  logic        clk,
    input  logic        rst_l,
    input  logic        row_len_valid,
    input  row_len_t    row_len,
    output logic        row_len_credit,
    input  logic        grp_valid,
    input  elem_group_t grp,
    output logic        grp_credit,
    output logic        out_valid,
    output byte_t       out_byte,
    input  logic        out_credit
);

    // ******************************
    // internal nets
    // ******************************
    row_len_t    len_head;
    logic [2:0]  len_level;
    logic        len_pop;
    elem_group_t grp_head;
    logic        grp_not_empty;
    logic        grp_pop;
    dec_group_t  dec;
    logic        dec_valid;
    result_vec_t sums;
    logic        result_ready;
    logic        capture;

    // row length queue, decoder reads its level
    credit_fifo #(.WIDTH($bits(row_len_t))) i_len_fifo (
        .clk, .rst_l,
        .in_valid (row_len_valid), .in_data (row_len),
        .pop      (len_pop),       .not_empty (),
        .level    (len_level),     .head (len_head),
        .credit   (row_len_credit)
    );

    // element group queue
    credit_fifo #(.WIDTH($bits(elem_group_t))) i_grp_fifo (
        .clk, .rst_l,
        .in_valid (grp_valid), .in_data (grp),
        .pop      (grp_pop),   .not_empty (grp_not_empty),
        .level    (),          .head (grp_head),
        .credit   (grp_credit)
    );

    cisr_row_decoder i_decoder (
        .clk, .rst_l,
        .len_head, .len_level, .len_pop,
        .grp_head, .grp_not_empty, .grp_pop,
        .dec, .dec_valid
    );

    row_accumulator i_accum (
        .clk, .rst_l, .dec, .dec_valid, .capture, .sums, .result_ready
    );

    result_serializer i_serializer (
        .clk, .rst_l, .sums, .result_ready, .capture,
        .out_valid, .out_byte, .out_credit
    );

endmodule

`default_nettype wire

// ==== rtl/result_serializer.sv ====
/*
 * Result serializer
 * snapshots the row sums and sends them little endian as credited bytes
 */
`timescale 1ns/10ps
`default_nettype none

module result_serializer import cisr_pkg::*; (
    input  logic        clk,
    input  logic        rst_l,
    input  result_vec_t sums,
    input  logic        result_ready,
    output logic        capture,
    output logic        out_valid,
    output byte_t       out_byte,
    input  logic        out_credit
);

    typedef enum logic {
        SER_IDLE,
        SER_SEND
    } ser_state_t;

    ser_state_t  state;
    byte_idx_t   byte_idx;
    credit_cnt_t credits;
    // payload copy, no reset
    result_vec_t snap;
    logic [$bits(result_vec_t)-1:0] snap_bits;

    // take a result only when free
    assign capture   = (state == SER_IDLE) && result_ready;
    // row 0 sits at the low end, so plain byte order is little endian
    assign snap_bits = snap;
    assign out_byte  = snap_bits[{byte_idx, 3'b000} +: 8];
    // stall on zero credit, index holds so nothing is lost
    assign out_valid = (state == SER_SEND) && (credits != '0);

    always_ff @(posedge clk) begin
        if (capture) begin
            snap <= sums;
        end
    end

    // ******************************
    // send FSM and credit count
    // ******************************
    always_ff @(posedge clk or negedge rst_l) begin
        if (!rst_l) begin
            state    <= SER_IDLE;
            byte_idx <= '0;
            credits  <= credit_cnt_t'(OUT_CREDITS);
        end else begin
            // returned credit and spent byte may meet in one cycle
            credits <= credits + credit_cnt_t'(out_credit) - credit_cnt_t'(out_valid);
            case (state)
                SER_IDLE: begin
                    if (capture) begin
                        state <= SER_SEND;
                    end
                end
                SER_SEND: begin
                    if (out_valid) begin
                        if (byte_idx == byte_idx_t'(RESULT_BYTES - 1)) begin
                            state    <= SER_IDLE;
                            byte_idx <= '0;
                        end else begin
                            byte_idx <= byte_idx + 1'b1;
                        end
                    end
                end
                default: begin
                    state <= SER_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/row_accumulator.sv ====
/*
 * Row accumulator
 * adds decoded elements into per row sums, flags a finished matrix
 */
`timescale 1ns/10ps
`default_nettype none

module row_accumulator import cisr_pkg::*; (
    input  logic        clk,
    input  logic        rst_l,
    input  dec_group_t  dec,
    input  logic        dec_valid,
    input  logic        capture,
    output result_vec_t sums,
    output logic        result_ready
);

    result_vec_t sums_next;
    // final group seen, sums land this cycle
    logic        fin_q;

    // ******************************
    // per row adders
    // ******************************
    always_comb begin
        for (int r = 0; r < NUM_ROWS; r++) begin
            // capture hands the old sums over, next matrix starts at zero
            sums_next[r] = capture ? acc_t'(0) : sums[r];
            for (int i = 0; i < NUM_LANES; i++) begin
                if (dec_valid && dec.lanes[i].valid && (dec.lanes[i].row == row_id_t'(r))) begin
                    sums_next[r] = sums_next[r] + acc_t'(dec.lanes[i].value);
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_l) begin
        if (!rst_l) begin
            sums         <= '0;
            fin_q        <= 1'b0;
            result_ready <= 1'b0;
        end else begin
            sums  <= sums_next;
            fin_q <= dec_valid && dec.last;
            // set wins over clear, held until the serializer takes it
            if (fin_q) begin
                result_ready <= 1'b1;
            end else if (capture) begin
                result_ready <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/cisr_row_decoder.sv ====
/*
 * CISR row decoder
 * hands rows to lanes in CISR order and tags every element with its row id
 */
`timescale 1ns/10ps
`default_nettype none

module cisr_row_decoder import cisr_pkg::*; (
    input  logic        clk,
    input  logic        rst_l,
    input  row_len_t    len_head,
    input  logic [2:0]  len_level,
    output logic        len_pop,
    input  elem_group_t grp_head,
    input  logic        grp_not_empty,
    output logic        grp_pop,
    output dec_group_t  dec,
    output logic        dec_valid
);

    // per lane state
    row_len_t  rem     [NUM_LANES];
    row_id_t   cur_row [NUM_LANES];
    // next row to hand out
    row_id_t   next_row;

    logic      pad       [NUM_LANES];
    logic      need      [NUM_LANES];
    row_len_t  eff_rem   [NUM_LANES];
    row_id_t   eff_row   [NUM_LANES];
    row_len_t  rem_after [NUM_LANES];
    logic [2:0] need_cnt;
    lane_idx_t first_need;
    logic      found;
    logic      all_zero;
    row_id_t   rows_next;
    logic      last_grp;

    // ******************************
    // lane scan
    // ******************************
    always_comb begin
        need_cnt   = '0;
        first_need = '0;
        found      = 1'b0;
        for (int i = 0; i < NUM_LANES; i++) begin
            pad[i]  = (grp_head[i].col == COL_PAD);
            // live lane with its row used up
            need[i] = grp_not_empty && !pad[i] && (rem[i] == '0);
            if (need[i]) begin
                need_cnt = need_cnt + 3'd1;
                if (!found) begin
                    // lowest lane gets the earlier row
                    first_need = lane_idx_t'(i);
                    found      = 1'b1;
                end
            end
        end
        // one length per cycle, lowest needy lane first
        len_pop = found && (len_level != 3'd0);
        // group goes once its last missing length arrives
        grp_pop = grp_not_empty && ((need_cnt == 3'd0) || ((need_cnt == 3'd1) && len_pop));

        for (int i = 0; i < NUM_LANES; i++) begin
            eff_rem[i] = rem[i];
            eff_row[i] = cur_row[i];
            if (len_pop && (first_need == lane_idx_t'(i))) begin
                eff_rem[i] = len_head;
                eff_row[i] = next_row;
            end
            rem_after[i] = eff_rem[i];
            if (grp_pop && !pad[i]) begin
                rem_after[i] = eff_rem[i] - 1'b1;
            end
        end
        rows_next = next_row + row_id_t'(len_pop);

        // matrix done when all rows handed out and drained
        all_zero = 1'b1;
        for (int i = 0; i < NUM_LANES; i++) begin
            if (rem_after[i] != '0) begin
                all_zero = 1'b0;
            end
        end
        last_grp = grp_pop && (rows_next == row_id_t'(NUM_ROWS)) && all_zero;
    end

    // ******************************
    // state and output register
    // ******************************
    always_ff @(posedge clk or negedge rst_l) begin
        if (!rst_l) begin
            for (int i = 0; i < NUM_LANES; i++) begin
                rem[i]     <= '0;
                cur_row[i] <= '0;
            end
            next_row  <= '0;
            dec       <= '0;
            dec_valid <= 1'b0;
        end else begin
            for (int i = 0; i < NUM_LANES; i++) begin
                rem[i]               <= rem_after[i];
                cur_row[i]           <= eff_row[i];
                dec.lanes[i].valid   <= grp_pop && !pad[i];
                dec.lanes[i].value   <= grp_head[i].value;
                dec.lanes[i].row     <= eff_row[i];
            end
            // row numbering restarts with the next matrix
            next_row  <= last_grp ? '0 : rows_next;
            dec.last  <= last_grp;
            dec_valid <= grp_pop;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/credit_fifo.sv ====
/*
 * Credit FIFO
 * small input queue, head visible while not empty, one credit pulse per pop
 */
`timescale 1ns/10ps
`default_nettype none

module credit_fifo import cisr_pkg::*; #(
    parameter int WIDTH = 8
) (
    input  logic             clk,
    input  logic             rst_l,
    input  logic             in_valid,
    input  logic [WIDTH-1:0] in_data,
    input  logic             pop,
    output logic             not_empty,
    output logic [2:0]       level,
    output logic [WIDTH-1:0] head,
    output logic             credit
);

    // storage, no reset
    logic [WIDTH-1:0]      mem [IN_FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic                  push_ok;
    logic                  pop_ok;

    // host spends credits, so full should never be hit
    assign push_ok   = in_valid && (level != 3'(IN_FIFO_DEPTH));
    assign pop_ok    = pop && not_empty;
    assign not_empty = (level != 3'd0);
    // head shown same cycle as pop
    assign head      = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem[wr_ptr] <= in_data;
        end
    end

    // ******************************
    // pointers, level, credit
    // ******************************
    always_ff @(posedge clk or negedge rst_l) begin
        if (!rst_l) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
            credit <= 1'b0;
        end else begin
            // pointers wrap on their own
            if (push_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            level  <= level + 3'(push_ok) - 3'(pop_ok);
            // one pulse per entry freed, a cycle after the pop
            credit <= pop_ok;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/cisr_pkg.sv ====
/*
 * CISR sparse engine definitions
 * sizes, plain vector types and the packed structs shared by the SpMV blocks
 */
`default_nettype none

package cisr_pkg;

    // ******************************
    // sizes
    // ******************************
    localparam int NUM_LANES     = 4;
    localparam int NUM_ROWS      = 6;
    localparam int IN_FIFO_DEPTH = 4;
    localparam int OUT_CREDITS   = 4;
    localparam int ACC_BYTES     = 4;
    localparam int RESULT_BYTES  = NUM_ROWS * ACC_BYTES;
    // fifo pointer width, depth is a power of two
    localparam int FIFO_PTR_W    = $clog2(IN_FIFO_DEPTH);

    // ******************************
    // plain vector types
    // ******************************
    typedef logic signed [15:0] value_t;
    typedef logic [7:0]         col_t;
    typedef logic [7:0]         row_len_t;
    typedef logic [2:0]         row_id_t;
    typedef logic signed [31:0] acc_t;
    typedef logic [7:0]         byte_t;
    typedef logic [$clog2(NUM_LANES)-1:0]    lane_idx_t;
    typedef logic [$clog2(RESULT_BYTES)-1:0] byte_idx_t;
    typedef logic [$clog2(OUT_CREDITS+1)-1:0] credit_cnt_t;

    // empty lane marker in the column field
    localparam col_t COL_PAD = 8'hff;

    // ******************************
    // structs
    // ******************************
    typedef struct packed {
        value_t value;
        col_t   col;
    } lane_elem_t;

    typedef lane_elem_t [NUM_LANES-1:0] elem_group_t;

    typedef struct packed {
        logic    valid;
        value_t  value;
        row_id_t row;
    } dec_lane_t;

    typedef struct packed {
        logic                        last;
        dec_lane_t [NUM_LANES-1:0]   lanes;
    } dec_group_t;

    typedef acc_t [NUM_ROWS-1:0] result_vec_t;

endpackage

`default_nettype wire
